// ==== build.sh ====
#!/usr/bin/env bash
# Compile and run the TDOA estimator testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f xcorrPeak.f --top-module tdoaEstimatorTb -o simv

output="$(./obj_dir/simv)"
echo "$output"

if echo "$output" | grep -qx "TEST PASSED"; then
    exit 0
else
    exit 1
fi

// ==== design/bufferArbiter.sv ====
// Buffer arbiter: round-robin sharing of the sample buffer read port between two correlators
`timescale 1ns/1ps
`include "xcorr_cfg.svh"

module bufferArbiter (
    input  logic                      clk50M,
    input  logic                      arstN,
    input  logic [`XC_NUM_PAIRS-1:0]  rdReq,
    input  xcorrPkg::addrT            rdAddr0,
    input  xcorrPkg::addrT            rdAddr1,
    output logic [`XC_NUM_PAIRS-1:0]  rdGrant,
    output logic [`XC_NUM_PAIRS-1:0]  rdValid,
    output logic                      memRdEn,
    output xcorrPkg::addrT            memRdAddr
);

    import xcorrPkg::*;

    // Requester served most recently
    logic lastServed;

    always_comb begin
        if (rdReq[0] && rdReq[1]) begin
            // Both waiting, the other one goes first
            rdGrant = lastServed ? 2'b01 : 2'b10;
        end else begin
            rdGrant = rdReq;
        end
    end

    assign memRdEn   = |rdGrant;
    assign memRdAddr = rdGrant[1] ? rdAddr1 : rdAddr0;

    always_ff @(posedge clk50M or negedge arstN) begin
        if (!arstN) begin
            lastServed <= 1'b0;
            rdValid    <= '0;
        end else begin
            // Buffer data lines up with the delayed grant
            rdValid <= rdGrant;
            if (rdGrant[1]) begin
                lastServed <= 1'b1;
            end else if (rdGrant[0]) begin
                lastServed <= 1'b0;
            end
        end
    end

    grantOneHot: assert property (@(posedge clk50M) disable iff (!arstN)
        $onehot0(rdGrant) && $onehot0(rdValid));

    // A held request that loses once wins on the next cycle
    fairReq0: assert property (@(posedge clk50M) disable iff (!arstN)
        rdReq[0] && !rdGrant[0] |=> rdGrant[0]);
    fairReq1: assert property (@(posedge clk50M) disable iff (!arstN)
        rdReq[1] && !rdGrant[1] |=> rdGrant[1]);

endmodule

// ==== design/crossCorrelator.sv ====
// Cross-correlator: accumulates mic0 times one other channel over all lags of a frame
`timescale 1ns/1ps
`include "xcorr_cfg.svh"

module crossCorrelator #(
    parameter int OTHER_CH = 1
) (
    input  logic                                  clk50M,
    input  logic                                  arstN,
    input  logic                                  corrStart,
    output logic                                  rdReq,
    output xcorrPkg::addrT                        rdAddr,
    input  logic                                  rdGrant,
    input  logic                                  rdValid,
    input  xcorrPkg::frameWordT                   rdData,
    output logic                                  corrDone,
    output xcorrPkg::corrT [`XC_NUM_LAGS-1:0]     corr
);

    import xcorrPkg::*;

    localparam addrT   LAST_ADDR = addrT'(`XC_NUM_SAMPLES - 1);
    localparam lagIdxT LAST_LAG  = lagIdxT'(`XC_NUM_LAGS - 1);

    corrStateT state;
    addrT      n;
    lagIdxT    lag;
    logic      waitData;
    sampleT    refSample;
    sampleT    otherSample;
    corrT      product;
    logic signed [7:0] otherPos;
    logic      otherInRange;
    logic      advance;

    assign otherSample = rdData[OTHER_CH*`XC_SAMPLE_BITS +: `XC_SAMPLE_BITS];
    assign product     = refSample * otherSample;

    // Position n+k of the other sample for the current lag
    assign otherPos     = $signed({2'b00, n}) + $signed({4'b0000, lag}) - 8'(`XC_MAX_LAGS);
    assign otherInRange = (otherPos >= 0) && (otherPos < `XC_NUM_SAMPLES);

    // Lag finished, either accumulated or outside the frame
    assign advance = (state == cReadOther) &&
                     (rdValid || (!rdReq && !waitData && !otherInRange));

    always_ff @(posedge clk50M or negedge arstN) begin
        if (!arstN) begin
            state    <= cIdle;
            n        <= '0;
            lag      <= '0;
            rdReq    <= 1'b0;
            rdAddr   <= '0;
            waitData <= 1'b0;
            corrDone <= 1'b0;
        end else begin
            corrDone <= 1'b0;
            if (rdReq && rdGrant) begin
                rdReq    <= 1'b0;
                waitData <= 1'b1;
            end
            case (state)
                cIdle: begin
                    if (corrStart) begin
                        n     <= '0;
                        lag   <= '0;
                        state <= cReadRef;
                    end
                end
                cReadRef: begin
                    if (!rdReq && !waitData) begin
                        rdReq  <= 1'b1;
                        rdAddr <= n;
                    end else if (rdValid) begin
                        waitData <= 1'b0;
                        lag      <= '0;
                        state    <= cReadOther;
                    end
                end
                cReadOther: begin
                    if (rdValid) begin
                        waitData <= 1'b0;
                    end else if (!rdReq && !waitData && otherInRange) begin
                        rdReq  <= 1'b1;
                        rdAddr <= otherPos[$bits(addrT)-1:0];
                    end
                    if (advance) begin
                        if (lag == LAST_LAG) begin
                            lag <= '0;
                            if (n == LAST_ADDR) begin
                                state <= cDone;
                            end else begin
                                n     <= n + 1'b1;
                                state <= cReadRef;
                            end
                        end else begin
                            lag <= lag + 1'b1;
                        end
                    end
                end
                cDone: begin
                    corrDone <= 1'b1;
                    state    <= cIdle;
                end
                default: state <= cIdle;
            endcase
        end
    end

    // Accumulators and reference sample
    always_ff @(posedge clk50M) begin
        if (corrStart) begin
            corr <= '0;
        end else if (state == cReadOther && rdValid) begin
            corr[lag] <= corr[lag] + product;
        end
        if (state == cReadRef && rdValid) begin
            refSample <= rdData[`XC_SAMPLE_BITS-1:0];
        end
    end

    addrHeld: assert property (@(posedge clk50M) disable iff (!arstN)
        rdReq && !rdGrant |=> rdReq && $stable(rdAddr));

endmodule

// ==== design/peakFinder.sv ====
// Peak finder: picks the lag with the largest correlation and tests it against the threshold
`timescale 1ns/1ps
`include "xcorr_cfg.svh"

module peakFinder (
    input  logic                              clk50M,
    input  logic                              arstN,
    input  logic                              corrDone,
    input  xcorrPkg::corrT [`XC_NUM_LAGS-1:0] corr,
    output logic                              peakDone,
    output xcorrPkg::lagIdxT                  peakIdx,
    output logic                              peakFound
);

    import xcorrPkg::*;

    localparam lagIdxT LAST_LAG = lagIdxT'(`XC_NUM_LAGS - 1);

    logic   scanning;
    lagIdxT scanIdx;
    corrT   maxVal;
    lagIdxT maxIdx;
    logic   isGreater;
    corrT   nextMax;
    lagIdxT nextIdx;

    // Strictly greater keeps ties at the lowest index
    assign isGreater = corr[scanIdx] > maxVal;
    assign nextMax   = isGreater ? corr[scanIdx] : maxVal;
    assign nextIdx   = isGreater ? scanIdx : maxIdx;

    always_ff @(posedge clk50M or negedge arstN) begin
        if (!arstN) begin
            scanning  <= 1'b0;
            scanIdx   <= '0;
            peakDone  <= 1'b0;
            peakIdx   <= '0;
            peakFound <= 1'b0;
        end else begin
            peakDone <= 1'b0;
            if (corrDone) begin
                scanning <= 1'b1;
                scanIdx  <= '0;
            end else if (scanning) begin
                scanIdx <= scanIdx + 1'b1;
                if (scanIdx == LAST_LAG) begin
                    scanning  <= 1'b0;
                    peakDone  <= 1'b1;
                    peakIdx   <= nextIdx;
                    peakFound <= nextMax >= `XC_MIN_CORR;
                end
            end
        end
    end

    // Running maximum starts at the most negative value
    always_ff @(posedge clk50M) begin
        if (corrDone) begin
            maxVal <= {1'b1, {($bits(corrT)-1){1'b0}}};
            maxIdx <= '0;
        end else if (scanning) begin
            maxVal <= nextMax;
            maxIdx <= nextIdx;
        end
    end

    idxInRange: assert property (@(posedge clk50M) disable iff (!arstN)
        peakIdx <= LAST_LAG);

    // One lag per cycle, then the registered result
    fixedLatency: assert property (@(posedge clk50M) disable iff (!arstN)
        corrDone |-> ##10 peakDone);

endmodule

// ==== design/sampleBuffer.sv ====
// Sample buffer: one frame of three-channel words, one write port, one registered read port
`timescale 1ns/1ps
`include "xcorr_cfg.svh"

module sampleBuffer (
    input  logic                clk50M,
    input  logic                wrEn,
    input  xcorrPkg::addrT      wrAddr,
    input  xcorrPkg::frameWordT wrData,
    input  logic                rdEn,
    input  xcorrPkg::addrT      rdAddr,
    output xcorrPkg::frameWordT rdData
);

    import xcorrPkg::*;

    frameWordT mem [`XC_NUM_SAMPLES];

    // Frame collection fills the memory
    always_ff @(posedge clk50M) begin
        if (wrEn) begin
            mem[wrAddr] <= wrData;
        end
    end

    // Data appears the cycle after the arbiter grant
    always_ff @(posedge clk50M) begin
        if (rdEn) begin
            rdData <= mem[rdAddr];
        end
    end

endmodule

// ==== design/tdoaControl.sv ====
// TDOA control for frame collection and for sequencing correlation, peak search and result report
`timescale 1ns/1ps
`include "xcorr_cfg.svh"

module tdoaControl (
    input  logic           clk50M,
    input  logic           arstN,
    input  logic           sampleValid,
    output logic           wrEn,
    output xcorrPkg::addrT wrAddr,
    output logic           corrStart,
    input  logic           peakDone01,
    input  logic           peakDone02,
    output logic           busy,
    output logic           delayValid
);

    import xcorrPkg::*;

    localparam addrT LAST_ADDR = addrT'(`XC_NUM_SAMPLES - 1);

    ctrlStateT state;
    logic      got01;
    logic      got02;
    logic      bothDone;
    logic      lastWrite;

    assign busy       = (state == sCorrelate);
    assign delayValid = (state == sReport);

    // Strobes while busy are dropped
    assign wrEn      = sampleValid && !busy;
    assign lastWrite = wrEn && (wrAddr == LAST_ADDR);
    assign bothDone  = (got01 || peakDone01) && (got02 || peakDone02);

    always_ff @(posedge clk50M or negedge arstN) begin
        if (!arstN) begin
            state     <= sIdle;
            wrAddr    <= '0;
            corrStart <= 1'b0;
            got01     <= 1'b0;
            got02     <= 1'b0;
        end else begin
            corrStart <= 1'b0;
            // Wraps to zero after the last word
            if (wrEn) begin
                wrAddr <= wrAddr + 1'b1;
            end
            case (state)
                sIdle: begin
                    if (lastWrite) begin
                        corrStart <= 1'b1;
                        got01     <= 1'b0;
                        got02     <= 1'b0;
                        state     <= sCorrelate;
                    end
                end
                sCorrelate: begin
                    if (peakDone01) begin
                        got01 <= 1'b1;
                    end
                    if (peakDone02) begin
                        got02 <= 1'b1;
                    end
                    if (bothDone) begin
                        state <= sReport;
                    end
                end
                sReport: state <= sIdle;
                default: state <= sIdle;
            endcase
        end
    end

    // The write counter rests at word zero for the whole of processing
    noWriteWhenBusy: assert property (@(posedge clk50M) disable iff (!arstN)
        busy |-> (wrAddr == '0));

endmodule

// ==== design/tdoaEstimator.sv ====
// TDOA estimator top: frame buffer, two arbitrated cross-correlators and their peak finders
`timescale 1ns/1ps
`include "xcorr_cfg.svh"

module tdoaEstimator (
    input  logic             clk50M,
    input  logic             arstN,
    input  xcorrPkg::sampleT mic0,
    input  xcorrPkg::sampleT mic1,
    input  xcorrPkg::sampleT mic2,
    input  logic             sampleValid,
    output logic             busy,
    output xcorrPkg::lagIdxT lag01,
    output xcorrPkg::lagIdxT lag02,
    output logic             found01,
    output logic             found02,
    output logic             delayValid
);

    import xcorrPkg::*;

    logic                          wrEn;
    addrT                          wrAddr;
    logic                          corrStart;
    logic [`XC_NUM_PAIRS-1:0]      rdReq;
    logic [`XC_NUM_PAIRS-1:0]      rdGrant;
    logic [`XC_NUM_PAIRS-1:0]      rdValid;
    addrT                          rdAddr0;
    addrT                          rdAddr1;
    logic                          memRdEn;
    addrT                          memRdAddr;
    frameWordT                     memRdData;
    logic                          corrDone01;
    logic                          corrDone02;
    corrT [`XC_NUM_LAGS-1:0]       corr01;
    corrT [`XC_NUM_LAGS-1:0]       corr02;
    logic                          peakDone01;
    logic                          peakDone02;

    tdoaControl u_tdoaControl (
        .clk50M(clk50M), .arstN(arstN), .sampleValid(sampleValid),
        .wrEn(wrEn), .wrAddr(wrAddr), .corrStart(corrStart),
        .peakDone01(peakDone01), .peakDone02(peakDone02),
        .busy(busy), .delayValid(delayValid)
    );

    // mic0 in the low bits of the word
    sampleBuffer u_sampleBuffer (
        .clk50M(clk50M), .wrEn(wrEn), .wrAddr(wrAddr), .wrData({mic2, mic1, mic0}),
        .rdEn(memRdEn), .rdAddr(memRdAddr), .rdData(memRdData)
    );

    bufferArbiter u_bufferArbiter (
        .clk50M(clk50M), .arstN(arstN), .rdReq(rdReq),
        .rdAddr0(rdAddr0), .rdAddr1(rdAddr1), .rdGrant(rdGrant), .rdValid(rdValid),
        .memRdEn(memRdEn), .memRdAddr(memRdAddr)
    );

    crossCorrelator #(.OTHER_CH(1)) u_crossCorrelator01 (
        .clk50M(clk50M), .arstN(arstN), .corrStart(corrStart),
        .rdReq(rdReq[0]), .rdAddr(rdAddr0), .rdGrant(rdGrant[0]), .rdValid(rdValid[0]),
        .rdData(memRdData), .corrDone(corrDone01), .corr(corr01)
    );

    crossCorrelator #(.OTHER_CH(2)) u_crossCorrelator02 (
        .clk50M(clk50M), .arstN(arstN), .corrStart(corrStart),
        .rdReq(rdReq[1]), .rdAddr(rdAddr1), .rdGrant(rdGrant[1]), .rdValid(rdValid[1]),
        .rdData(memRdData), .corrDone(corrDone02), .corr(corr02)
    );

    peakFinder u_peakFinder01 (
        .clk50M(clk50M), .arstN(arstN), .corrDone(corrDone01), .corr(corr01),
        .peakDone(peakDone01), .peakIdx(lag01), .peakFound(found01)
    );

    peakFinder u_peakFinder02 (
        .clk50M(clk50M), .arstN(arstN), .corrDone(corrDone02), .corr(corr02),
        .peakDone(peakDone02), .peakIdx(lag02), .peakFound(found02)
    );

endmodule

// ==== design/xcorrPkg.sv ====
// Shared vector types and state encodings of the TDOA estimator
`include "xcorr_cfg.svh"

package xcorrPkg;

    // One signed microphone sample
    typedef logic signed [`XC_SAMPLE_BITS-1:0] sampleT;

    // Three samples of one time step, mic0 in the low bits
    typedef logic [3*`XC_SAMPLE_BITS-1:0] frameWordT;

    typedef logic [$clog2(`XC_NUM_SAMPLES)-1:0] addrT;

    // Product bits, accumulation bits and one guard bit
    typedef logic signed [2*`XC_SAMPLE_BITS+$clog2(`XC_NUM_SAMPLES):0] corrT;

    // Lag plus XC_MAX_LAGS
    typedef logic [$clog2(`XC_NUM_LAGS)-1:0] lagIdxT;

    typedef enum logic [1:0] {sIdle, sCorrelate, sReport} ctrlStateT;

    typedef enum logic [1:0] {cIdle, cReadRef, cReadOther, cDone} corrStateT;

endpackage

// ==== design/xcorr_cfg.svh ====
// Cross-correlation TDOA configuration: frame size, lag range, sample width and peak threshold
`ifndef XCORR_CFG_SVH
`define XCORR_CFG_SVH

// Samples per frame and per channel
`define XC_NUM_SAMPLES 64

// Largest absolute lag in samples
`define XC_MAX_LAGS 4

// Number of lags from -XC_MAX_LAGS to +XC_MAX_LAGS
`define XC_NUM_LAGS (2 * `XC_MAX_LAGS + 1)

// Width of one signed microphone sample
`define XC_SAMPLE_BITS 12

// Correlator peers sharing the sample buffer
`define XC_NUM_PAIRS 2

// A maximum below this is not reported as a peak
`define XC_MIN_CORR 1

`endif

// ==== verif/tdoaEstimatorTb.sv ====
// TDOA estimator testbench with random frames checked against a correlation and peak model
`timescale 1ns/1ps
`include "xcorr_cfg.svh"

module tdoaEstimatorTb;

    import xcorrPkg::*;

    localparam int RESULT_TIMEOUT = 20000;
    localparam int MODE_RANDOM    = 0;
    localparam int MODE_DELAY     = 1;
    localparam int MODE_NEGATE    = 2;

    logic   clk50M;
    logic   arstN;
    sampleT mic0;
    sampleT mic1;
    sampleT mic2;
    logic   sampleValid;
    logic   busy;
    lagIdxT lag01;
    lagIdxT lag02;
    logic   found01;
    logic   found02;
    logic   delayValid;

    logic [31:0] rngState;
    sampleT      frame0 [`XC_NUM_SAMPLES];
    sampleT      frame1 [`XC_NUM_SAMPLES];
    sampleT      frame2 [`XC_NUM_SAMPLES];
    int          lagErrors;
    int          foundErrors;
    int          levelErrors;
    int          timeouts;
    bit          aborted;

    tdoaEstimator u_tdoaEstimator (
        .clk50M(clk50M), .arstN(arstN),
        .mic0(mic0), .mic1(mic1), .mic2(mic2), .sampleValid(sampleValid),
        .busy(busy), .lag01(lag01), .lag02(lag02),
        .found01(found01), .found02(found02), .delayValid(delayValid)
    );

    always #10 clk50M = ~clk50M;

    function automatic logic [31:0] nextRandom();
        logic [31:0] x;
        x = rngState;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rngState = x;
        return x;
    endfunction

    function automatic sampleT randomSample();
        logic [31:0] r;
        r = nextRandom();
        return r[`XC_SAMPLE_BITS-1:0];
    endfunction

    task automatic checkLag(input string name, input lagIdxT expected, input lagIdxT actual);
        if (actual !== expected) begin
            lagErrors++;
            $display("[ERROR] %0t %s expected %0d actual %0d", $time, name, expected, actual);
        end
    endtask

    task automatic checkFound(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            foundErrors++;
            $display("[ERROR] %0t %s expected %0b actual %0b", $time, name, expected, actual);
        end
    endtask

    task automatic checkLevel(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            levelErrors++;
            $display("[ERROR] %0t %s expected %0b actual %0b", $time, name, expected, actual);
        end
    endtask

    // Delayed copies come from one longer base signal
    task automatic buildFrame(input int mode);
        sampleT base [`XC_NUM_SAMPLES + 2*`XC_MAX_LAGS];
        int     d1;
        int     d2;
        sampleT level;
        d1 = int'(nextRandom() % 9) - `XC_MAX_LAGS;
        d2 = int'(nextRandom() % 9) - `XC_MAX_LAGS;
        level = sampleT'((nextRandom() % 1000) + 1);
        foreach (base[i]) begin
            base[i] = randomSample();
        end
        for (int n = 0; n < `XC_NUM_SAMPLES; n++) begin
            case (mode)
                MODE_DELAY: begin
                    frame0[n] = base[n + `XC_MAX_LAGS];
                    frame1[n] = base[n + `XC_MAX_LAGS - d1];
                    frame2[n] = base[n + `XC_MAX_LAGS - d2];
                end
                // Constant level keeps every lag of pair 01 negative
                MODE_NEGATE: begin
                    frame0[n] = level;
                    frame1[n] = -level;
                    frame2[n] = '0;
                end
                default: begin
                    frame0[n] = randomSample();
                    frame1[n] = randomSample();
                    frame2[n] = randomSample();
                end
            endcase
        end
        if (mode == MODE_DELAY) begin
            $display("Planted lag indices %0d and %0d", d1 + `XC_MAX_LAGS, d2 + `XC_MAX_LAGS);
        end
    endtask

    // Lag k pairs reference n with other n+k
    task automatic modelPair(input int ch, output lagIdxT expLag, output bit expFound);
        longint sum;
        longint best;
        int     other;
        best   = 0;
        expLag = '0;
        for (int k = -`XC_MAX_LAGS; k <= `XC_MAX_LAGS; k++) begin
            sum = 0;
            for (int n = 0; n < `XC_NUM_SAMPLES; n++) begin
                if (n + k >= 0 && n + k < `XC_NUM_SAMPLES) begin
                    other = (ch == 1) ? int'(frame1[n + k]) : int'(frame2[n + k]);
                    sum += longint'(int'(frame0[n])) * other;
                end
            end
            // Ties go to the lowest index
            if (k == -`XC_MAX_LAGS || sum > best) begin
                best   = sum;
                expLag = lagIdxT'(k + `XC_MAX_LAGS);
            end
        end
        expFound = best >= `XC_MIN_CORR;
    endtask

    task automatic sendFrame();
        for (int n = 0; n < `XC_NUM_SAMPLES; n++) begin
            @(posedge clk50M);
            #1;
            mic0        = frame0[n];
            mic1        = frame1[n];
            mic2        = frame2[n];
            sampleValid = 1'b1;
        end
        @(posedge clk50M);
        #1;
        sampleValid = 1'b0;
    endtask

    task automatic waitIdle();
        int cycles;
        cycles = 0;
        while (busy && cycles < RESULT_TIMEOUT) begin
            @(posedge clk50M);
            #1;
            cycles++;
        end
        if (busy) begin
            timeouts++;
            aborted = 1'b1;
            $display("Timeout: busy stayed high for %0d cycles", RESULT_TIMEOUT);
        end
    endtask

    // Garbage strobes land while busy and must be dropped
    task automatic waitResult(input bit garbage);
        int          cycles;
        bit          seen;
        logic [31:0] r;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < RESULT_TIMEOUT) begin
            @(posedge clk50M);
            #1;
            cycles++;
            if (delayValid) begin
                seen = 1'b1;
            end else if (garbage) begin
                r           = nextRandom();
                mic0        = randomSample();
                mic1        = randomSample();
                mic2        = randomSample();
                sampleValid = r[0];
            end
        end
        sampleValid = 1'b0;
        if (!seen) begin
            timeouts++;
            aborted = 1'b1;
            $display("Timeout: no delayValid within %0d cycles", RESULT_TIMEOUT);
        end
    endtask

    task automatic runFrame(input int mode, input bit garbage);
        lagIdxT exp01;
        lagIdxT exp02;
        bit     expFound01;
        bit     expFound02;
        if (!aborted) begin
            buildFrame(mode);
            modelPair(1, exp01, expFound01);
            modelPair(2, exp02, expFound02);
            waitIdle();
            if (!aborted) begin
                sendFrame();
                waitResult(garbage);
            end
            if (!aborted) begin
                checkLag("lag01", exp01, lag01);
                checkLag("lag02", exp02, lag02);
                checkFound("found01", expFound01, found01);
                checkFound("found02", expFound02, found02);
            end
        end
    endtask

    initial begin
        clk50M      = 1'b0;
        arstN       = 1'b0;
        mic0        = '0;
        mic1        = '0;
        mic2        = '0;
        sampleValid = 1'b0;
        rngState    = 32'h59ef93f2;
        lagErrors   = 0;
        foundErrors = 0;
        levelErrors = 0;
        timeouts    = 0;
        aborted     = 1'b0;
        repeat (10) @(posedge clk50M);
        #1;
        arstN = 1'b1;

        // Quiet after reset with no samples
        repeat (20) begin
            @(posedge clk50M);
            #1;
            checkLevel("busy", 1'b0, busy);
            checkLevel("delayValid", 1'b0, delayValid);
        end

        repeat (3) runFrame(MODE_RANDOM, 1'b0);
        repeat (4) runFrame(MODE_DELAY, 1'b0);
        runFrame(MODE_NEGATE, 1'b0);
        repeat (2) runFrame(MODE_RANDOM, 1'b1);
        // Back-to-back frames start as soon as busy is low
        for (int i = 0; i < 10; i++) begin
            runFrame(i % 3, i[0]);
        end

        $display("Errors: lag %0d, found %0d, level %0d, timeouts %0d",
                 lagErrors, foundErrors, levelErrors, timeouts);
        if (lagErrors + foundErrors + levelErrors + timeouts == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== xcorrPeak.f ====
+incdir+design
design/xcorrPkg.sv
design/sampleBuffer.sv
design/bufferArbiter.sv
design/crossCorrelator.sv
design/peakFinder.sv
design/tdoaControl.sv
design/tdoaEstimator.sv
verif/tdoaEstimatorTb.sv
